// ==== logic/ts_pkg.sv ====
package ts_pkg;

	// every transport packet opens with this byte
	localparam logic [7:0] sync_byte = 8'h47;

	// fixed by the MPEG transport-stream format
	localparam int packet_bytes = 188;

	// the PID spans the low five bits of header byte 1 and all of byte 2
	localparam int pid_width = 13;

endpackage

// ==== logic/replacer_pkg.sv ====
package replacer_pkg;

	localparam int word_bytes = 4; // one software word carries four stream bytes

	// 188 bytes fill exactly 47 words, so no word is partly used
	localparam int packet_words = ts_pkg::packet_bytes / word_bytes;

	// software writes and reads whole words while the splicer picks single bytes
	typedef union packed {
		logic [31:0] word;
		logic [word_bytes-1:0][7:0] bytes; // lane k sits in bits 8k+7 down to 8k
	} store_word_u;

endpackage

// ==== logic/ts_header_tap.sv ====
module ts_header_tap (
	input  logic                          S_AXI_ACLK,
	input  logic                          S_AXI_ARESETN,

	input  logic [7:0]                    mpeg_data,
	input  logic                          mpeg_valid,
	input  logic                          mpeg_sync,

	output logic [7:0]                    tap_byte,
	output logic                          tap_valid,
	output logic                          header_seen,
	output logic [ts_pkg::pid_width-1:0]  header_pid
);

	logic [7:0] data_d1;
	logic [7:0] data_d2;
	logic [7:0] data_d3;

	logic sync_d1;
	logic sync_d2;
	logic sync_d3;

	logic fill_d1;
	logic fill_d2;
	logic fill_d3;

	// sync and filled flags move with the bytes and only on valid beats
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			sync_d1 <= 1'b0;
			sync_d2 <= 1'b0;
			sync_d3 <= 1'b0;
			fill_d1 <= 1'b0;
			fill_d2 <= 1'b0;
			fill_d3 <= 1'b0;
		end
		else if (mpeg_valid) begin
			sync_d1 <= mpeg_sync;
			sync_d2 <= sync_d1;
			sync_d3 <= sync_d2;
			fill_d1 <= 1'b1;
			fill_d2 <= fill_d1;
			fill_d3 <= fill_d2;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (mpeg_valid) begin
			data_d1 <= mpeg_data;
			data_d2 <= data_d1;
			data_d3 <= data_d2;
		end
	end

	assign tap_byte  = data_d3;
	assign tap_valid = mpeg_valid && fill_d3; // stage 3 leaves on this beat

	// a sync marker on any other value is noise and starts nothing
	assign header_seen = tap_valid && sync_d3 && (data_d3 == ts_pkg::sync_byte);

	// the two bytes behind the sync byte sit in stages 2 and 1
	assign header_pid = {data_d2[4:0], data_d1};

endmodule

// ==== logic/replace_packet_ram.sv ====
module replace_packet_ram (
	input  logic        S_AXI_ACLK,
	input  logic        S_AXI_ARESETN,

	input  logic        store_enable,
	input  logic [5:0]  store_index,
	input  logic [31:0] store_data,

	input  logic        pump_enable,
	output logic [31:0] out_data,
	output logic [5:0]  out_index,
	output logic        readback_done,

	input  logic [7:0]  byte_addr,
	output logic [7:0]  replace_byte
);

	replacer_pkg::store_word_u mem [replacer_pkg::packet_words];

	logic [5:0] pump_count;
	logic [5:0] word_addr;
	logic [1:0] lane;
	logic       word_in_range;

	// software side fills the packet one word per strobe
	always_ff @(posedge S_AXI_ACLK) begin
		if (store_enable && (store_index < replacer_pkg::packet_words)) begin
			mem[store_index].word <= store_data; // indices past the packet are dropped
		end
	end

	// lane k of word w in the union holds stream byte 4w+k
	assign word_addr     = 6'(byte_addr / replacer_pkg::word_bytes);
	assign lane          = 2'(byte_addr % replacer_pkg::word_bytes);
	assign word_in_range = word_addr < replacer_pkg::packet_words;

	always_comb begin
		replace_byte = 8'h00;
		if (word_in_range) begin
			replace_byte = mem[word_addr].bytes[lane];
		end
	end

	// the pump walks the store once per rising level of pump_enable
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			pump_count    <= 6'd0;
			out_index     <= 6'd0;
			readback_done <= 1'b0;
		end
		else if (pump_enable) begin
			if (pump_count < replacer_pkg::packet_words) begin
				out_index  <= pump_count;
				pump_count <= pump_count + 6'd1;
			end
			else begin
				readback_done <= 1'b1; // held until the level drops
			end
		end
		else begin
			pump_count    <= 6'd0;
			readback_done <= 1'b0;
		end
	end

	// read data follows the same count as out_index
	always_ff @(posedge S_AXI_ACLK) begin
		if (pump_enable && (pump_count < replacer_pkg::packet_words)) begin
			out_data <= mem[pump_count].word;
		end
	end

endmodule

// ==== logic/ts_splicer.sv ====
module ts_splicer (
	input  logic                          S_AXI_ACLK,
	input  logic                          S_AXI_ARESETN,

	input  logic [ts_pkg::pid_width-1:0]  pid,
	input  logic                          pass_through,

	input  logic [7:0]                    tap_byte,
	input  logic                          tap_valid,
	input  logic                          header_seen,
	input  logic [ts_pkg::pid_width-1:0]  header_pid,

	output logic [7:0]                    byte_addr,
	input  logic [7:0]                    replace_byte,

	output logic [7:0]                    ts_out,
	output logic                          ts_out_valid,
	output logic                          replacing
);

	logic       matched;
	logic [7:0] byte_index;

	logic       pid_hit;
	logic       cur_match;
	logic [7:0] cur_index;
	logic       index_in_packet;
	logic       use_replace;

	assign pid_hit = header_pid == pid;

	// on a header beat the new decision and index 0 already apply
	assign cur_match = header_seen ? pid_hit : matched;
	assign cur_index = header_seen ? 8'd0 : byte_index;

	assign byte_addr = cur_index; // store answers in the same clock

	assign index_in_packet = cur_index < ts_pkg::packet_bytes;

	// bytes past 187 of a matched packet come from the stream
	assign use_replace = !pass_through && cur_match && index_in_packet;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			matched      <= 1'b0;
			byte_index   <= 8'd0;
			ts_out_valid <= 1'b0;
			replacing    <= 1'b0;
		end
		else begin
			ts_out_valid <= tap_valid;
			replacing    <= pass_through || cur_match;

			if (header_seen) begin
				matched    <= pid_hit;
				byte_index <= 8'd1; // the sync byte took index 0
			end
			else if (tap_valid && (byte_index < ts_pkg::packet_bytes)) begin
				byte_index <= byte_index + 8'd1; // stops at 188 so it never wraps
			end
		end
	end

	// output byte only moves with a beat
	always_ff @(posedge S_AXI_ACLK) begin
		if (tap_valid) begin
			if (use_replace) begin
				ts_out <= replace_byte;
			end
			else begin
				ts_out <= tap_byte;
			end
		end
	end

endmodule

// ==== logic/ts_replacer_top.sv ====
module ts_replacer_top (
	input  logic                          S_AXI_ACLK,
	input  logic                          S_AXI_ARESETN,

	input  logic                          store_enable,
	input  logic [5:0]                    store_index,
	input  logic [31:0]                   store_data,

	input  logic                          pump_enable,
	output logic [31:0]                   out_data,
	output logic [5:0]                    out_index,
	output logic                          readback_done,

	input  logic [ts_pkg::pid_width-1:0]  pid,
	input  logic                          pass_through,
	input  logic [7:0]                    mpeg_data,
	input  logic                          mpeg_valid,
	input  logic                          mpeg_sync,

	output logic [7:0]                    ts_out,
	output logic                          ts_out_valid,
	output logic                          replacing
);

	logic [7:0]                   tap_byte;
	logic                         tap_valid;
	logic                         header_seen;
	logic [ts_pkg::pid_width-1:0] header_pid;

	logic [7:0] byte_addr;
	logic [7:0] replace_byte;

	ts_header_tap tap_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.mpeg_data     (mpeg_data),
		.mpeg_valid    (mpeg_valid),
		.mpeg_sync     (mpeg_sync),
		.tap_byte      (tap_byte),
		.tap_valid     (tap_valid),
		.header_seen   (header_seen),
		.header_pid    (header_pid)
	);

	replace_packet_ram store_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.store_enable  (store_enable),
		.store_index   (store_index),
		.store_data    (store_data),
		.pump_enable   (pump_enable),
		.out_data      (out_data),
		.out_index     (out_index),
		.readback_done (readback_done),
		.byte_addr     (byte_addr),
		.replace_byte  (replace_byte)
	);

	ts_splicer splicer_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.pid           (pid),
		.pass_through  (pass_through),
		.tap_byte      (tap_byte),
		.tap_valid     (tap_valid),
		.header_seen   (header_seen),
		.header_pid    (header_pid),
		.byte_addr     (byte_addr),
		.replace_byte  (replace_byte),
		.ts_out        (ts_out),
		.ts_out_valid  (ts_out_valid),
		.replacing     (replacing)
	);

endmodule

// ==== sim/ts_replacer_checker.sv ====
module ts_replacer_checker (
	input logic       S_AXI_ACLK,
	input logic       S_AXI_ARESETN,
	input logic       tap_valid,
	input logic       ts_out_valid,
	input logic [5:0] out_index,
	input logic       readback_done
);

	int error_count = 0;

	// every output strobe echoes a tap beat from the clock before
	out_valid_follows_beat: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		ts_out_valid |-> $past(tap_valid))
		else begin
			$error("ts_out_valid without a tap beat one clock earlier");
			error_count++;
		end

	// once the pump is done the index must sit still
	done_holds_index: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(readback_done && (out_index != $past(out_index))))
		else begin
			$error("out_index moved while readback_done was high");
			error_count++;
		end

	index_in_store: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		out_index < replacer_pkg::packet_words)
		else begin
			$error("out_index left the 47 word store");
			error_count++;
		end

endmodule

bind ts_replacer_top ts_replacer_checker checker_i (
	.S_AXI_ACLK    (S_AXI_ACLK),
	.S_AXI_ARESETN (S_AXI_ARESETN),
	.tap_valid     (tap_valid),
	.ts_out_valid  (ts_out_valid),
	.out_index     (out_index),
	.readback_done (readback_done)
);

// ==== sim/ts_replacer_tb.sv ====
module ts_replacer_tb;

	logic                         S_AXI_ACLK;
	logic                         S_AXI_ARESETN;
	logic                         store_enable;
	logic [5:0]                   store_index;
	logic [31:0]                  store_data;
	logic                         pump_enable;
	logic [31:0]                  out_data;
	logic [5:0]                   out_index;
	logic                         readback_done;
	logic [ts_pkg::pid_width-1:0] pid;
	logic                         pass_through;
	logic [7:0]                   mpeg_data;
	logic                         mpeg_valid;
	logic                         mpeg_sync;
	logic [7:0]                   ts_out;
	logic                         ts_out_valid;
	logic                         replacing;

	logic [31:0] store_copy [replacer_pkg::packet_words];
	logic [7:0]  stage_data [1:3];
	logic        stage_sync [1:3];
	logic        stage_fill [1:3];
	logic        model_matched;
	int          model_index;
	logic        expect_replacing;
	logic [7:0]  expect_bytes [$];

	string       trace_lines [$];
	int          budget_cycles;
	bit          trace_loaded = 1'b0;
	logic [31:0] lfsr_state;

	ts_replacer_top dut_i (.*);

	always #2 S_AXI_ACLK = ~S_AXI_ACLK;

	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	task automatic stop_on_error();
		$display("tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// expectations for the coming rising edge follow from the inputs driven now
	task automatic model_beat();
		logic                         header;
		logic                         cur_match;
		logic [ts_pkg::pid_width-1:0] seen_pid;
		logic [31:0]                  word;
		int                           s;
		if (!S_AXI_ARESETN) begin
			for (s = 1; s <= 3; s++) begin
				stage_fill[s] = 1'b0;
				stage_sync[s] = 1'b0;
			end
			model_matched    = 1'b0;
			expect_replacing = 1'b0;
		end
		else begin
			cur_match = model_matched;
			if (mpeg_valid && stage_fill[3]) begin
				header   = stage_sync[3] && (stage_data[3] == ts_pkg::sync_byte);
				seen_pid = {stage_data[2][4:0], stage_data[1]};
				if (header) begin
					cur_match   = seen_pid == pid;
					model_index = 0; // the sync byte is byte 0
				end
				if (!pass_through && cur_match && model_index < ts_pkg::packet_bytes) begin
					word = store_copy[model_index / 4];
					expect_bytes.push_back(word[8 * (model_index % 4) +: 8]);
				end
				else begin
					expect_bytes.push_back(stage_data[3]);
				end
				model_matched = cur_match;
				model_index++;
			end
			expect_replacing = pass_through || cur_match;
			if (mpeg_valid) begin
				for (s = 3; s > 1; s--) begin
					stage_data[s] = stage_data[s-1];
					stage_sync[s] = stage_sync[s-1];
					stage_fill[s] = stage_fill[s-1];
				end
				stage_data[1] = mpeg_data;
				stage_sync[1] = mpeg_sync;
				stage_fill[1] = 1'b1;
			end
		end
	endtask

	task automatic check_outputs();
		logic [7:0] want;
		assert (dut_i.checker_i.error_count == 0) else begin
			$display("a bound assertion on the top level failed");
			stop_on_error();
		end
		assert (replacing === expect_replacing) else begin
			$display("** Error: replacing = %h, expected %h", replacing, expect_replacing);
			stop_on_error();
		end
		if (ts_out_valid !== 1'b0) begin
			assert (expect_bytes.size() > 0) else begin
				$display("ts_out_valid pulsed while no output byte was due");
				stop_on_error();
			end
			want = expect_bytes.pop_front();
			assert (ts_out === want) else begin
				$display("** Error: ts_out = %h, expected %h", ts_out, want);
				stop_on_error();
			end
		end
		assert (expect_bytes.size() == 0) else begin
			$display("ts_out_valid missed the clock after a tap beat");
			stop_on_error();
		end
	endtask

	task automatic tick();
		model_beat();
		@(negedge S_AXI_ACLK);
		check_outputs();
	endtask

	task automatic store_words(input logic [5:0] first, input int count, input logic [31:0] base);
		logic [5:0] i;
		int         k;
		for (k = 0; k < count; k++) begin
			i             = first + 6'(k);
			store_enable  = 1'b1;
			store_index   = i;
			store_data    = base ^ {4{2'b00, i}}; // every byte lane sees the whole index
			store_copy[i] = store_data;
			tick();
		end
		store_enable = 1'b0;
	endtask

	task automatic send_bytes(input logic [7:0] value, input logic sync, input logic valid,
			input int count);
		logic [7:0] b;
		logic       gap_a;
		logic       gap_b;
		int         k;
		b = value;
		for (k = 0; k < count; k++) begin
			gap_a = lfsr_bit();
			gap_b = lfsr_bit();
			if (valid && gap_a && gap_b) begin
				mpeg_valid = 1'b0; // roughly one beat in four gets an idle clock
				tick();
			end
			mpeg_data  = b;
			mpeg_sync  = sync;
			mpeg_valid = valid;
			tick();
			b = b + 8'd1;
		end
		mpeg_valid = 1'b0;
		mpeg_sync  = 1'b0;
	endtask

	task automatic pump_readback();
		int k;
		pump_enable = 1'b1;
		for (k = 0; k < replacer_pkg::packet_words; k++) begin
			tick();
			assert (out_index === 6'(k)) else begin
				$display("** Error: out_index = %h, expected %h", out_index, 6'(k));
				stop_on_error();
			end
			assert (out_data === store_copy[k]) else begin
				$display("** Error: out_data = %h, expected %h", out_data, store_copy[k]);
				stop_on_error();
			end
			assert (readback_done === 1'b0) else begin
				$display("** Error: readback_done = %h, expected %h", readback_done, 1'b0);
				stop_on_error();
			end
		end
		for (k = 0; k < 4; k++) begin
			tick();
			assert (readback_done === 1'b1) else begin
				$display("** Error: readback_done = %h, expected %h", readback_done, 1'b1);
				stop_on_error();
			end
		end
		pump_enable = 1'b0;
		tick();
		assert (readback_done === 1'b0) else begin
			$display("** Error: readback_done = %h, expected %h", readback_done, 1'b0);
			stop_on_error();
		end
	endtask

	task automatic load_trace();
		int          fd;
		int          work;
		string       line;
		string       cmd;
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] a2;
		logic [31:0] a3;
		fd = $fopen("sim/replacer_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file sim/replacer_trace.txt");
			stop_on_error();
		end
		else begin
			work = 8;
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#") begin
					trace_lines.push_back(line);
					a1 = 0;
					a3 = 0;
					void'($sscanf(line, "%s %h %h %h %h", cmd, a0, a1, a2, a3));
					if (cmd == "store")
						work += a1;
					else if (cmd == "byte")
						work += 2 * a3; // a byte may bring an idle clock along
					else if (cmd == "pump")
						work += replacer_pkg::packet_words + 8;
					else
						work += 1;
				end
			end
			$fclose(fd);
			budget_cycles = 8 * work;
			trace_loaded  = 1'b1;
		end
	endtask

	task automatic run_line(input string line);
		string       cmd;
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] a2;
		logic [31:0] a3;
		void'($sscanf(line, "%s %h %h %h %h", cmd, a0, a1, a2, a3));
		if (cmd == "store") begin
			store_words(a0[5:0], int'(a1), a2);
		end
		else if (cmd == "pid") begin
			pid = a0[ts_pkg::pid_width-1:0];
			tick();
		end
		else if (cmd == "pass") begin
			pass_through = a0[0];
			tick();
		end
		else if (cmd == "byte") begin
			send_bytes(a0[7:0], a1[0], a2[0], int'(a3));
		end
		else if (cmd == "pump") begin
			pump_readback();
		end
		else begin
			$display("the trace holds an unknown command %s", cmd);
			stop_on_error();
		end
	endtask

	initial begin
		wait (trace_loaded);
		repeat (budget_cycles) @(posedge S_AXI_ACLK);
		$display("watchdog expired after %0d clocks before the trace was done", budget_cycles);
		stop_on_error();
	end

	initial begin
		S_AXI_ACLK    = 1'b0;
		S_AXI_ARESETN = 1'b0;
		store_enable  = 1'b0;
		store_index   = 6'd0;
		store_data    = 32'd0;
		pump_enable   = 1'b0;
		pid           = '0;
		pass_through  = 1'b0;
		mpeg_data     = 8'd0;
		mpeg_valid    = 1'b0;
		mpeg_sync     = 1'b0;
		lfsr_state    = 32'hb23f_67f3;
		model_index   = 0;
		load_trace();
		repeat (5) tick();
		S_AXI_ARESETN = 1'b1;
		foreach (trace_lines[i]) begin
			run_line(trace_lines[i]);
		end
		tick();
		tick();
		$display("all tests passed");
		$finish;
	end

endmodule

// ==== sim/replacer_trace.txt ====
# command  arguments in hex
# store first_index count base, word i = base ^ {4{2'b00, i}} | pid value | pass level
# byte value sync valid count, value counts up over count | pump
store 00 2f 11223344
pump
pid 0100
pass 0
byte 47 1 1 1
byte 41 0 1 1
byte 00 0 1 1
byte 10 0 1 b9
byte 47 1 1 1
byte 02 0 1 1
byte 00 0 1 1
byte 20 0 1 b9
byte 47 1 1 1
byte 41 0 1 1
byte 00 0 1 1
byte 30 0 1 50
byte 55 1 1 1
byte 31 0 1 68
byte 99 0 1 4
byte 00 0 0 6
pass 1
byte 47 1 1 1
byte 41 0 1 1
byte 00 0 1 1
byte 60 0 1 b9
pass 0
store 05 01 cafef00d
pump
byte 47 1 1 1
byte 1f 0 1 1
byte ff 0 1 1
byte 70 0 1 b9
byte 47 1 1 1
byte 41 0 1 1
byte 00 0 1 1
byte 80 0 1 b9
byte 47 1 1 1
byte 02 0 1 3

// ==== sources.f ====
logic/ts_pkg.sv
logic/replacer_pkg.sv
logic/ts_header_tap.sv
logic/replace_packet_ram.sv
logic/ts_splicer.sv
logic/ts_replacer_top.sv
sim/ts_replacer_checker.sv
sim/ts_replacer_tb.sv

// ==== Bender.yml ====
package:
  name: ts_replacer

sources:
  - logic/ts_pkg.sv
  - logic/replacer_pkg.sv
  - logic/ts_header_tap.sv
  - logic/replace_packet_ram.sv
  - logic/ts_splicer.sv
  - logic/ts_replacer_top.sv
  - target: simulation
    files:
      - sim/ts_replacer_checker.sv
      - sim/ts_replacer_tb.sv
